//--- source/mem_bridge_pkg.sv
package mem_bridge_pkg;

    typedef logic [31:0] addr_t;                  // byte address
    typedef logic [31:0] word_t;                  // one 32-bit AXI beat

    localparam int LINE_WORDS = 8;                // words per cache line
    localparam int LINE_BYTES = LINE_WORDS * 4;   // used for line alignment

    typedef logic [LINE_WORDS*32-1:0] line_t;     // word 0 sits in the low bits

    localparam logic [3:0] BURST_LEN = 4'(LINE_WORDS - 1);  // AXI len field for a line

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_ADDR,
        ARB_DATA
    } arb_state_t;

    typedef enum logic [1:0] {
        RF_IDLE,
        RF_ADDR,
        RF_COLLECT,
        RF_DONE
    } refill_state_t;

    typedef enum logic [1:0] {
        WB_EMPTY,
        WB_ADDR,
        WB_DATA,
        WB_RESP
    } wb_state_t;

endpackage

//--- source/axi_rd_if.sv
interface axi_rd_if;
    import mem_bridge_pkg::*;

    logic       arvalid;
    addr_t      araddr;
    logic [3:0] arlen;    // beats minus one
    logic       arready;
    logic       rvalid;
    word_t      rdata;
    logic       rlast;
    logic       rready;

    modport requester (
        output arvalid, araddr, arlen, rready,
        input  arready, rvalid, rdata, rlast
    );

    modport arbiter (
        input  arvalid, araddr, arlen, rready,
        output arready, rvalid, rdata, rlast
    );

endinterface

//--- source/read_arbiter.sv
module read_arbiter (
    input  logic                  aclk,
    input  logic                  reset_i,
    axi_rd_if.arbiter             ifr,
    axi_rd_if.arbiter             lfr,
    output logic                  arvalid_o,
    output mem_bridge_pkg::addr_t araddr_o,
    output logic [3:0]            arlen_o,
    input  logic                  arready_i,
    input  logic                  rvalid_i,
    input  mem_bridge_pkg::word_t rdata_i,
    input  logic                  rlast_i,
    output logic                  rready_o
);
    import mem_bridge_pkg::*;

    arb_state_t state_q;
    logic       owner_lfr_q;    // grant holder, 1 for the line refill
    logic       sel_lfr;
    logic       addr_phase;
    logic       data_phase;

    assign addr_phase = (state_q != ARB_DATA);
    assign data_phase = (state_q == ARB_DATA);

    // refill wins when both ask in the same idle cycle
    assign sel_lfr = (state_q == ARB_IDLE) ? lfr.arvalid : owner_lfr_q;

    assign arvalid_o = addr_phase && (sel_lfr ? lfr.arvalid : ifr.arvalid);
    assign araddr_o  = sel_lfr ? lfr.araddr : ifr.araddr;
    assign arlen_o   = sel_lfr ? lfr.arlen : ifr.arlen;

    assign lfr.arready = addr_phase && sel_lfr && arready_i;
    assign ifr.arready = addr_phase && !sel_lfr && arready_i;

    // only one read is outstanding, so the latched owner routes every beat
    assign rready_o   = data_phase && (owner_lfr_q ? lfr.rready : ifr.rready);
    assign lfr.rvalid = data_phase && owner_lfr_q && rvalid_i;
    assign ifr.rvalid = data_phase && !owner_lfr_q && rvalid_i;

    assign lfr.rdata = rdata_i;
    assign ifr.rdata = rdata_i;
    assign lfr.rlast = rlast_i;
    assign ifr.rlast = rlast_i;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q     <= ARB_IDLE;
            owner_lfr_q <= 1'b0;
        end else begin
            case (state_q)
                ARB_IDLE: begin
                    if (lfr.arvalid || ifr.arvalid) begin
                        owner_lfr_q <= lfr.arvalid;
                        state_q     <= arready_i ? ARB_DATA : ARB_ADDR;  // skip wait if taken now
                    end
                end
                ARB_ADDR: begin
                    if (arready_i) begin
                        state_q <= ARB_DATA;
                    end
                end
                ARB_DATA: begin
                    if (rvalid_i && rready_o && rlast_i) begin
                        state_q <= ARB_IDLE;    // grant ends with the last beat
                    end
                end
                default: begin
                    state_q <= ARB_IDLE;
                end
            endcase
        end
    end

endmodule

//--- source/inst_read_adapter.sv
module inst_read_adapter (
    input  logic                  aclk,
    input  logic                  reset_i,
    input  logic                  if_req_i,
    input  mem_bridge_pkg::addr_t if_addr_i,
    input  logic                  if_flush_i,
    output logic                  if_ready_o,
    output logic                  if_valid_o,
    output mem_bridge_pkg::word_t if_data_o,
    output mem_bridge_pkg::addr_t if_data_addr_o,
    axi_rd_if.requester           rd
);
    import mem_bridge_pkg::*;

    logic  busy_q;       // a read is outstanding
    logic  arvalid_q;
    logic  discard_q;    // flushed while outstanding
    logic  valid_q;
    addr_t addr_q;
    word_t data_q;
    logic  accept;
    logic  beat_done;

    assign accept    = if_req_i && if_ready_o;
    assign beat_done = rd.rvalid && rd.rready && rd.rlast;

    assign if_ready_o     = !busy_q;
    assign if_valid_o     = valid_q;
    assign if_data_o      = data_q;
    assign if_data_addr_o = addr_q;    // held until the next accepted fetch

    assign rd.arvalid = arvalid_q;
    assign rd.araddr  = addr_q;
    assign rd.arlen   = 4'd0;          // single beat
    assign rd.rready  = busy_q && !arvalid_q;

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            busy_q    <= 1'b0;
            arvalid_q <= 1'b0;
            discard_q <= 1'b0;
            valid_q   <= 1'b0;
        end else begin
            valid_q <= 1'b0;
            if (accept) begin
                busy_q    <= 1'b1;
                arvalid_q <= 1'b1;
                discard_q <= 1'b0;
            end
            if (rd.arvalid && rd.arready) begin
                arvalid_q <= 1'b0;
            end
            if (busy_q && if_flush_i) begin
                discard_q <= 1'b1;
            end
            if (beat_done) begin
                busy_q  <= 1'b0;
                valid_q <= !(discard_q || if_flush_i);  // stale word is dropped
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= if_addr_i;
        end
        if (beat_done) begin
            data_q <= rd.rdata;
        end
    end

endmodule

//--- source/line_refill.sv
module line_refill (
    input  logic                  aclk,
    input  logic                  reset_i,
    input  logic                  lr_req_i,
    input  mem_bridge_pkg::addr_t lr_addr_i,
    output logic                  lr_ready_o,
    output logic                  lr_valid_o,
    output mem_bridge_pkg::line_t lr_line_o,
    output mem_bridge_pkg::addr_t lookup_addr_o,
    input  logic                  lookup_hit_i,
    input  mem_bridge_pkg::line_t lookup_line_i,
    axi_rd_if.requester           rd
);
    import mem_bridge_pkg::*;

    refill_state_t                   state_q;
    logic [$clog2(LINE_WORDS)-1:0]   beat_q;    // next word slot of the line
    addr_t                           addr_q;
    line_t                           line_q;
    logic                            accept;
    logic                            beat_ok;

    assign accept  = lr_req_i && lr_ready_o;
    assign beat_ok = rd.rvalid && rd.rready;

    assign lookup_addr_o = lr_addr_i & ~addr_t'(LINE_BYTES - 1);  // line aligned

    assign lr_ready_o = (state_q == RF_IDLE);
    assign lr_valid_o = (state_q == RF_DONE);
    assign lr_line_o  = line_q;

    assign rd.arvalid = (state_q == RF_ADDR);
    assign rd.araddr  = addr_q;
    assign rd.arlen   = BURST_LEN;
    assign rd.rready  = (state_q == RF_COLLECT);

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q <= RF_IDLE;
            beat_q  <= '0;
        end else begin
            case (state_q)
                RF_IDLE: begin
                    if (accept) begin
                        state_q <= lookup_hit_i ? RF_DONE : RF_ADDR;  // hit answers next cycle
                    end
                end
                RF_ADDR: begin
                    if (rd.arready) begin
                        state_q <= RF_COLLECT;
                        beat_q  <= '0;
                    end
                end
                RF_COLLECT: begin
                    if (beat_ok) begin
                        beat_q <= beat_q + 1'b1;
                        if (rd.rlast) begin
                            state_q <= RF_DONE;
                        end
                    end
                end
                default: begin
                    state_q <= RF_IDLE;    // done lasts one cycle
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= lookup_addr_o;
            if (lookup_hit_i) begin
                line_q <= lookup_line_i;    // copy from the write buffer
            end
        end
        if (state_q == RF_COLLECT && beat_ok) begin
            line_q[beat_q*32 +: 32] <= rd.rdata;
        end
    end

endmodule

//--- source/wbuffer.sv
module wbuffer (
    input  logic                  aclk,
    input  logic                  reset_i,
    input  logic                  lw_req_i,
    input  mem_bridge_pkg::addr_t lw_addr_i,
    input  mem_bridge_pkg::line_t lw_line_i,
    output logic                  lw_ack_o,
    output logic                  wb_empty_o,
    input  mem_bridge_pkg::addr_t lookup_addr_i,
    output logic                  lookup_hit_o,
    output mem_bridge_pkg::line_t lookup_line_o,
    output logic                  awvalid_o,
    output mem_bridge_pkg::addr_t awaddr_o,
    output logic [3:0]            awlen_o,
    input  logic                  awready_i,
    output logic                  wvalid_o,
    output mem_bridge_pkg::word_t wdata_o,
    output logic                  wlast_o,
    input  logic                  wready_i,
    input  logic                  bvalid_i,
    output logic                  bready_o
);
    import mem_bridge_pkg::*;

    localparam addr_t LINE_MASK = ~addr_t'(LINE_BYTES - 1);

    wb_state_t                     state_q;
    logic [$clog2(LINE_WORDS)-1:0] beat_q;    // word being written
    addr_t                         addr_q;    // aligned line address
    line_t                         line_q;
    logic                          accept;
    logic                          last_beat;

    assign accept    = lw_req_i && lw_ack_o;
    assign last_beat = (beat_q == LINE_WORDS - 1);

    assign lw_ack_o   = (state_q == WB_EMPTY);
    assign wb_empty_o = (state_q == WB_EMPTY);

    // buffered copy stays visible for the whole drain
    assign lookup_hit_o  = (state_q != WB_EMPTY) &&
                           ((lookup_addr_i & LINE_MASK) == addr_q);
    assign lookup_line_o = line_q;

    assign awvalid_o = (state_q == WB_ADDR);
    assign awaddr_o  = addr_q;
    assign awlen_o   = BURST_LEN;

    assign wvalid_o = (state_q == WB_DATA);
    assign wdata_o  = line_q[beat_q*32 +: 32];
    assign wlast_o  = (state_q == WB_DATA) && last_beat;

    assign bready_o = (state_q == WB_RESP);

    always_ff @(posedge aclk) begin
        if (reset_i) begin
            state_q <= WB_EMPTY;
            beat_q  <= '0;
        end else begin
            case (state_q)
                WB_EMPTY: begin
                    if (accept) begin
                        state_q <= WB_ADDR;
                    end
                end
                WB_ADDR: begin
                    if (awready_i) begin
                        state_q <= WB_DATA;
                        beat_q  <= '0;
                    end
                end
                WB_DATA: begin
                    if (wready_i) begin
                        beat_q <= beat_q + 1'b1;
                        if (last_beat) begin
                            state_q <= WB_RESP;
                        end
                    end
                end
                WB_RESP: begin
                    if (bvalid_i) begin
                        state_q <= WB_EMPTY;    // free again next cycle
                    end
                end
                default: begin
                    state_q <= WB_EMPTY;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (accept) begin
            addr_q <= lw_addr_i & LINE_MASK;
            line_q <= lw_line_i;
        end
    end

endmodule

//--- source/mem_bridge_top.sv
module mem_bridge_top (
    input  logic                  aclk,
    input  logic                  reset_i,
    input  logic                  if_req_i,
    input  mem_bridge_pkg::addr_t if_addr_i,
    input  logic                  if_flush_i,
    output logic                  if_ready_o,
    output logic                  if_valid_o,
    output mem_bridge_pkg::word_t if_data_o,
    output mem_bridge_pkg::addr_t if_data_addr_o,
    input  logic                  lr_req_i,
    input  mem_bridge_pkg::addr_t lr_addr_i,
    output logic                  lr_ready_o,
    output logic                  lr_valid_o,
    output mem_bridge_pkg::line_t lr_line_o,
    input  logic                  lw_req_i,
    input  mem_bridge_pkg::addr_t lw_addr_i,
    input  mem_bridge_pkg::line_t lw_line_i,
    output logic                  lw_ack_o,
    output logic                  wb_empty_o,
    output logic                  arvalid_o,
    output mem_bridge_pkg::addr_t araddr_o,
    output logic [3:0]            arlen_o,
    input  logic                  arready_i,
    input  logic                  rvalid_i,
    input  mem_bridge_pkg::word_t rdata_i,
    input  logic                  rlast_i,
    output logic                  rready_o,
    output logic                  awvalid_o,
    output mem_bridge_pkg::addr_t awaddr_o,
    output logic [3:0]            awlen_o,
    input  logic                  awready_i,
    output logic                  wvalid_o,
    output mem_bridge_pkg::word_t wdata_o,
    output logic                  wlast_o,
    input  logic                  wready_i,
    input  logic                  bvalid_i,
    output logic                  bready_o
);
    import mem_bridge_pkg::*;

    axi_rd_if ifr();    // instruction reader side
    axi_rd_if lfr();    // line refill side

    addr_t lookup_addr;
    logic  lookup_hit;
    line_t lookup_line;

    read_arbiter u_read_arbiter (
        .aclk, .reset_i, .ifr, .lfr,
        .arvalid_o, .araddr_o, .arlen_o, .arready_i,
        .rvalid_i, .rdata_i, .rlast_i, .rready_o
    );

    inst_read_adapter u_inst_read_adapter (
        .aclk, .reset_i, .if_req_i, .if_addr_i, .if_flush_i,
        .if_ready_o, .if_valid_o, .if_data_o, .if_data_addr_o,
        .rd (ifr)
    );

    line_refill u_line_refill (
        .aclk, .reset_i, .lr_req_i, .lr_addr_i,
        .lr_ready_o, .lr_valid_o, .lr_line_o,
        .lookup_addr_o (lookup_addr),
        .lookup_hit_i  (lookup_hit),
        .lookup_line_i (lookup_line),
        .rd            (lfr)
    );

    wbuffer u_wbuffer (
        .aclk, .reset_i, .lw_req_i, .lw_addr_i, .lw_line_i, .lw_ack_o, .wb_empty_o,
        .lookup_addr_i (lookup_addr),
        .lookup_hit_o  (lookup_hit),
        .lookup_line_o (lookup_line),
        .awvalid_o, .awaddr_o, .awlen_o, .awready_i,
        .wvalid_o, .wdata_o, .wlast_o, .wready_i,
        .bvalid_i, .bready_o
    );

endmodule

//--- sim/mem_bridge_asserts.sv
module mem_bridge_asserts (
    input logic                  aclk,
    input logic                  reset_i,
    input logic                  arvalid_o,
    input logic                  arready_i,
    input mem_bridge_pkg::addr_t araddr_o,
    input logic                  awvalid_o,
    input logic                  awready_i,
    input logic                  wvalid_o,
    input logic                  wready_i,
    input mem_bridge_pkg::word_t wdata_o,
    input logic                  if_valid_o,
    input logic                  lr_valid_o
);

    ar_hold: assert property (@(posedge aclk) disable iff (reset_i)
        arvalid_o && !arready_i |=> arvalid_o && $stable(araddr_o))
        else $error("read address dropped or changed before arready");

    aw_hold: assert property (@(posedge aclk) disable iff (reset_i)
        awvalid_o && !awready_i |=> awvalid_o)
        else $error("awvalid dropped before awready");

    w_hold: assert property (@(posedge aclk) disable iff (reset_i)
        wvalid_o && !wready_i |=> wvalid_o && $stable(wdata_o))
        else $error("write beat dropped or changed before wready");

    // both result strobes are single-cycle pulses
    if_pulse: assert property (@(posedge aclk) disable iff (reset_i)
        if_valid_o |=> !if_valid_o)
        else $error("if_valid_o high for two cycles");

    lr_pulse: assert property (@(posedge aclk) disable iff (reset_i)
        lr_valid_o |=> !lr_valid_o)
        else $error("lr_valid_o high for two cycles");

endmodule

bind mem_bridge_top mem_bridge_asserts u_asserts (.*);

//--- sim/tb_mem_bridge.sv
module tb_mem_bridge;
    import mem_bridge_pkg::*;

    localparam int CLK_PERIOD = 8;
    localparam int WAIT_LIMIT = 100;    // cycles allowed for one handshake
    localparam int MEM_WORDS  = 1024;
    localparam int NUM_OPS    = 9;

    typedef enum logic [2:0] {
        OP_FETCH,
        OP_REFILL,
        OP_WRITE_REFILL,
        OP_FETCH_REFILL,
        OP_FLUSH,
        OP_WRITE_FULL
    } op_kind_t;

    typedef struct packed {
        op_kind_t kind;
        addr_t    addr_a;
        addr_t    addr_b;
        word_t    pattern;
    } op_row_t;

    // kind, first address, second address, line pattern
    op_row_t ops [NUM_OPS] = '{
        '{OP_FETCH,        32'h0000_0104, 32'h0000_0000, 32'h0000_0000},
        '{OP_REFILL,       32'h0000_0248, 32'h0000_0000, 32'h0000_0000},
        '{OP_WRITE_REFILL, 32'h0000_0300, 32'h0000_0000, 32'ha5a5_0000},
        '{OP_FETCH_REFILL, 32'h0000_001c, 32'h0000_0480, 32'h0000_0000},
        '{OP_FLUSH,        32'h0000_0060, 32'h0000_0064, 32'h0000_0000},
        '{OP_WRITE_FULL,   32'h0000_0500, 32'h0000_0520, 32'h3c3c_0000},
        '{OP_REFILL,       32'h0000_052c, 32'h0000_0000, 32'h0000_0000},
        '{OP_FETCH,        32'h0000_030c, 32'h0000_0000, 32'h0000_0000},
        '{OP_FETCH_REFILL, 32'h0000_0504, 32'h0000_0300, 32'h0000_0000}
    };

    logic       aclk;
    logic       reset_i;
    logic       if_req_i, if_flush_i, if_ready_o, if_valid_o;
    addr_t      if_addr_i, if_data_addr_o;
    word_t      if_data_o;
    logic       lr_req_i, lr_ready_o, lr_valid_o;
    addr_t      lr_addr_i;
    line_t      lr_line_o;
    logic       lw_req_i, lw_ack_o, wb_empty_o;
    addr_t      lw_addr_i;
    line_t      lw_line_i;
    logic       arvalid_o, arready_i, rvalid_i, rlast_i, rready_o;
    addr_t      araddr_o, awaddr_o;
    logic [3:0] arlen_o, awlen_o;
    word_t      rdata_i, wdata_o;
    logic       awvalid_o, awready_i, wvalid_o, wlast_o, wready_i, bvalid_i, bready_o;

    word_t mem     [MEM_WORDS];    // array behind the AXI port
    word_t exp_mem [MEM_WORDS];    // what memory should hold
    int    errors;
    int    passed;

    mem_bridge_top uut (.*);

    initial begin
        aclk = 1'b0;
        forever #(CLK_PERIOD / 2) aclk = ~aclk;
    end

    function automatic logic [9:0] word_index(addr_t a, int beat);
        return a[11:2] + 10'(beat);
    endfunction

    function automatic line_t make_line(word_t pattern);
        line_t l;
        for (int k = 0; k < LINE_WORDS; k++) begin
            l[k*32 +: 32] = pattern ^ (32'(k) * 32'h0101_0101);
        end
        return l;
    endfunction

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            $display("ERR %s got %h exp %h", name, got, exp);
            errors++;
        end
    endtask

    task automatic report_fail(string what);
        $display("%s", what);
        errors++;
    endtask

    task automatic random_wait();
        repeat ($urandom % 4) @(negedge aclk);
    endtask

    initial begin : read_slave
        addr_t      rd_addr;
        logic [3:0] rd_len;
        arready_i = 1'b0;
        rvalid_i  = 1'b0;
        rdata_i   = '0;
        rlast_i   = 1'b0;
        forever begin
            @(negedge aclk);
            if (arvalid_o && !reset_i) begin
                random_wait();
                arready_i = 1'b1;
                @(posedge aclk);
                rd_addr = araddr_o;
                rd_len  = arlen_o;
                @(negedge aclk);
                arready_i = 1'b0;
                for (int beat = 0; beat <= int'(rd_len); beat++) begin
                    random_wait();
                    rvalid_i = 1'b1;
                    rdata_i  = mem[word_index(rd_addr, beat)];
                    rlast_i  = (beat == int'(rd_len));
                    do @(posedge aclk); while (!rready_o);
                    @(negedge aclk);
                    rvalid_i = 1'b0;
                    rlast_i  = 1'b0;
                end
            end
        end
    end

    initial begin : write_slave
        addr_t wr_addr;
        awready_i = 1'b0;
        wready_i  = 1'b0;
        bvalid_i  = 1'b0;
        forever begin
            @(negedge aclk);
            if (awvalid_o && !reset_i) begin
                random_wait();
                awready_i = 1'b1;
                @(posedge aclk);
                wr_addr = awaddr_o;
                if (awlen_o !== 4'd7) begin    // eight beats per line
                    $display("ERR awlen_o got %h exp %h", awlen_o, 4'd7);
                    errors++;
                end
                @(negedge aclk);
                awready_i = 1'b0;
                for (int beat = 0; beat < LINE_WORDS; beat++) begin
                    random_wait();
                    wready_i = 1'b1;
                    do @(posedge aclk); while (!wvalid_o);
                    mem[word_index(wr_addr, beat)] = wdata_o;
                    if (wlast_o !== (beat == LINE_WORDS - 1)) begin
                        $display("ERR wlast_o got %h exp %h", wlast_o, beat == LINE_WORDS - 1);
                        errors++;
                    end
                    @(negedge aclk);
                    wready_i = 1'b0;
                end
                random_wait();
                bvalid_i = 1'b1;
                do @(posedge aclk); while (!bready_o);
                @(negedge aclk);
                bvalid_i = 1'b0;
            end
        end
    end

    task automatic fetch(input addr_t a, input logic flush);
        int   n;
        logic seen;
        logic done;
        @(negedge aclk);
        if_req_i  = 1'b1;
        if_addr_i = a;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!if_ready_o && n < WAIT_LIMIT);
        if (!if_ready_o) begin
            report_fail("fetch was never accepted");
        end
        @(negedge aclk);
        if_req_i   = 1'b0;
        if_flush_i = flush;    // one cycle while the read is outstanding
        if (flush) begin
            @(negedge aclk);
            if_flush_i = 1'b0;
        end
        n = 0;
        seen = 1'b0;
        do begin
            @(posedge aclk);
            n++;
            seen = seen | if_valid_o;
            done = flush ? if_ready_o : if_valid_o;
        end while (!done && n < WAIT_LIMIT);
        if (!done) begin
            report_fail("timeout waiting for the fetch to finish");
        end else if (flush) begin
            @(posedge aclk);
            if (seen || if_valid_o) begin
                report_fail("if_valid_o pulsed for a flushed fetch");
            end
        end else begin
            check_word("if_data_o", if_data_o, exp_mem[word_index(a, 0)]);
            check_word("if_data_addr_o", if_data_addr_o, a);
        end
    endtask

    task automatic refill(input addr_t a, input logic expect_hit);
        int    n;
        addr_t base;
        base = {a[31:5], 5'b00000};    // 32-byte line
        @(negedge aclk);
        lr_req_i  = 1'b1;
        lr_addr_i = a;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!lr_ready_o && n < WAIT_LIMIT);
        if (!lr_ready_o) begin
            report_fail("refill was never accepted");
        end
        @(negedge aclk);
        lr_req_i = 1'b0;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!lr_valid_o && n < WAIT_LIMIT);
        if (!lr_valid_o) begin
            report_fail("timeout waiting for lr_valid_o");
        end else begin
            if (expect_hit && n != 1) begin
                report_fail($sformatf("lr_valid_o came %0d cycles after a buffer hit", n));
            end
            for (int k = 0; k < LINE_WORDS; k++) begin
                check_word($sformatf("lr_line_o[%0d]", k), lr_line_o[k*32 +: 32],
                           exp_mem[word_index(base, k)]);
            end
        end
    endtask

    task automatic line_write(input addr_t a, input line_t l, output int waited);
        addr_t base;
        base = {a[31:5], 5'b00000};
        @(negedge aclk);
        lw_req_i  = 1'b1;
        lw_addr_i = a;
        lw_line_i = l;
        waited = 0;
        do begin
            @(posedge aclk);
            waited++;
        end while (!lw_ack_o && waited < WAIT_LIMIT);
        if (!lw_ack_o) begin
            report_fail("line write was never acknowledged");
        end
        for (int k = 0; k < LINE_WORDS; k++) begin
            exp_mem[word_index(base, k)] = l[k*32 +: 32];
        end
        @(negedge aclk);
        lw_req_i = 1'b0;
    endtask

    task automatic check_drained(input addr_t a);
        int         n;
        logic [9:0] idx;
        n = 0;
        do begin
            @(posedge aclk);
            n++;
        end while (!wb_empty_o && n < WAIT_LIMIT);
        if (!wb_empty_o) begin
            report_fail("timeout waiting for wb_empty_o");
        end
        for (int k = 0; k < LINE_WORDS; k++) begin
            idx = word_index({a[31:5], 5'b00000}, k);
            check_word($sformatf("mem[%h]", {idx, 2'b00}), mem[idx], exp_mem[idx]);
        end
    endtask

    task automatic run_op(input op_row_t op);
        int waited;
        case (op.kind)
            OP_FETCH: fetch(op.addr_a, 1'b0);
            OP_REFILL: refill(op.addr_a, 1'b0);
            OP_WRITE_REFILL: begin
                line_write(op.addr_a, make_line(op.pattern), waited);
                refill(op.addr_a, 1'b1);    // buffer still holds the line
                check_drained(op.addr_a);
            end
            OP_FETCH_REFILL: begin
                fork
                    fetch(op.addr_a, 1'b0);
                    refill(op.addr_b, 1'b0);
                join
            end
            OP_FLUSH: begin
                fetch(op.addr_a, 1'b1);
                fetch(op.addr_b, 1'b0);
            end
            OP_WRITE_FULL: begin
                line_write(op.addr_a, make_line(op.pattern), waited);
                line_write(op.addr_b, make_line(~op.pattern), waited);
                if (waited < 2) begin
                    report_fail("second line write was taken while the buffer was full");
                end
                check_drained(op.addr_a);
                check_drained(op.addr_b);
            end
            default: report_fail("unknown operation kind in the table");
        endcase
    endtask

    initial begin : watchdog
        #(CLK_PERIOD * (NUM_OPS * 200 + 8));
        $display("watchdog expired, tests did not finish in %0d cycles", NUM_OPS * 200 + 8);
        $display("sim failed");
        $finish;
    end

    initial begin : main
        int       errs_before;
        op_kind_t kind;
        void'($urandom(32'h5a5e_5fe5));
        errors     = 0;
        passed     = 0;
        reset_i    = 1'b1;
        if_req_i   = 1'b0;
        if_addr_i  = '0;
        if_flush_i = 1'b0;
        lr_req_i   = 1'b0;
        lr_addr_i  = '0;
        lw_req_i   = 1'b0;
        lw_addr_i  = '0;
        lw_line_i  = '0;
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = (32'(i) << 2) ^ 32'hc0de_0000;    // word equals its address xor key
            exp_mem[i] = (32'(i) << 2) ^ 32'hc0de_0000;
        end
        repeat (4) @(negedge aclk);
        reset_i = 1'b0;
        for (int i = 0; i < NUM_OPS; i++) begin
            errs_before = errors;
            kind        = ops[i].kind;
            run_op(ops[i]);
            if (errors == errs_before) begin
                passed++;
                $display("test %0d %s ok", i, kind.name());
            end else begin
                $display("test %0d %s FAILED", i, kind.name());
            end
        end
        $display("%0d of %0d tests passed, %0d errors", passed, NUM_OPS, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

//--- tb.f
source/mem_bridge_pkg.sv
source/axi_rd_if.sv
source/read_arbiter.sv
source/inst_read_adapter.sv
source/line_refill.sv
source/wbuffer.sv
source/mem_bridge_top.sv
sim/mem_bridge_asserts.sv
sim/tb_mem_bridge.sv

//--- Makefile
VERILATOR  ?= verilator
FLAGS      ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
TOP        := tb_mem_bridge
FILELIST   := tb.f
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "sim passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
